// File: pitch_core.f
+incdir+rtl
rtl/audio_pkg.sv
rtl/sdram_pkg.sv
rtl/frame_reader.sv
rtl/frame_buffer.sv
rtl/ola_writer.sv
rtl/sdram_arbiter.sv
rtl/pitch_core.sv
testbench/tb_pitch_core.sv

// File: rtl/audio_pkg.sv
// Hann table holds exactly 16 entries; a different window length needs a new table
`include "pitch_config.svh"

package audio_pkg;

    typedef logic signed [15:0] sample_t;   // One channel, two's complement

    typedef struct packed {
        sample_t left;                      // Upper half of the SDRAM word
        sample_t right;
    } stereo_t;

    // Word position inside a frame
    typedef logic [$clog2(`PITCH_WINDOW_LEN)-1:0] win_idx_t;

    typedef struct packed {
        logic first;                        // No tail from an earlier frame
        logic last;                         // Final frame of the run
    } frame_tag_t;

    // One windowed word headed for the frame buffer
    typedef struct packed {
        logic     slot;
        win_idx_t index;
        stereo_t  data;
    } buf_wr_t;

    // Periodic Hann, 0.5 * (1 - cos(2*pi*n/16)) in unsigned Q15
    // Centre tap is exactly 1.0, hence 16 bits unsigned
    localparam logic [15:0] hann_coef [`PITCH_WINDOW_LEN] = '{
        16'd0,     16'd1247,  16'd4799,  16'd10114,
        16'd16384, 16'd22654, 16'd27969, 16'd31522,
        16'd32768, 16'd31522, 16'd27969, 16'd22654,
        16'd16384, 16'd10114, 16'd4799,  16'd1247
    };

endpackage

// File: rtl/frame_buffer.sv
// Slots are handed over whole; a slot may not be refilled before its release
`include "pitch_config.svh"

module frame_buffer
    import audio_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  logic       wr_en,
    input  buf_wr_t    buf_wr,
    input  logic       fill_done,
    input  frame_tag_t fill_tag,
    input  logic       slot_release,
    input  logic       rd_en,
    input  logic       rd_slot,
    input  win_idx_t   rd_index,
    output stereo_t    rd_data,
    output logic [1:0] slot_full,
    output frame_tag_t slot_tag
);
    localparam int DEPTH = 2 * `PITCH_WINDOW_LEN;

    stereo_t    store [DEPTH];          // Slot is the top address bit
    frame_tag_t tags  [2];
    logic [1:0] set_mask;
    logic [1:0] clr_mask;

    always_ff @(posedge i_clk) begin
        if (wr_en) store[{buf_wr.slot, buf_wr.index}] <= buf_wr.data;
        if (rd_en) rd_data <= store[{rd_slot, rd_index}];   // One cycle read
        if (fill_done) tags[buf_wr.slot] <= fill_tag;
    end

    // Set follows the producer's slot, clear the consumer's
    assign set_mask = fill_done ? (2'b01 << buf_wr.slot) : 2'b00;
    assign clr_mask = slot_release ? (2'b01 << rd_slot) : 2'b00;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            slot_full <= 2'b00;
        end else begin
            slot_full <= (slot_full | set_mask) & ~clr_mask;
        end
    end

    assign slot_tag = tags[rd_slot];    // Tag of the slot being consumed

endmodule

// File: rtl/frame_reader.sv
// Header length taken from bits 31..9 assumes a 23-bit address; a trailing partial frame is dropped
`include "pitch_config.svh"

module frame_reader
    import audio_pkg::*;
    import sdram_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  logic       start,
    input  mem_addr_t  src_addr,
    input  logic [3:0] speed,
    output mem_req_t   mem_req,
    input  mem_data_t  mem_readdata,
    input  logic       finished,
    input  logic [1:0] slot_full,
    output logic       wr_en,
    output buf_wr_t    buf_wr,
    output logic       fill_done,
    output frame_tag_t fill_tag,
    output logic       empty_run
);
    typedef enum logic [2:0] {S_IDLE, S_HDR, S_WAIT, S_READ, S_EMPTY} state_e;

    state_e             state;
    mem_addr_t          src_q;
    mem_addr_t          hop;            // Analysis hop, fixed for the run
    mem_addr_t          length;
    mem_addr_t          frame_off;      // k * hop
    mem_addr_t          hdr_len;
    mem_addr_t          hop_next;
    win_idx_t           idx;
    logic               slot;
    logic               first_frame;
    logic               last_frame;
    logic [3:0]         speed_eff;
    logic [23:0]        frame_end;      // One bit spare for the compare
    stereo_t            word_in;
    stereo_t            word_win;
    logic signed [32:0] prod_l;
    logic signed [32:0] prod_r;

    always_comb begin
        speed_eff = (speed == 4'd0) ? 4'(1 << `PITCH_SPEED_FRAC) : speed;  // 0 means 1.0
        hop_next  = mem_addr_t'((`PITCH_SYN_HOP * speed_eff) >> `PITCH_SPEED_FRAC);
        hdr_len   = mem_readdata[31:9];
        // End of the frame after this one
        frame_end  = {1'b0, frame_off} + {1'b0, hop} + 24'(`PITCH_WINDOW_LEN);
        last_frame = frame_end > {1'b0, length};
        word_in  = stereo_t'(mem_readdata);
        prod_l   = $signed(word_in.left) * $signed({1'b0, hann_coef[idx]});
        prod_r   = $signed(word_in.right) * $signed({1'b0, hann_coef[idx]});
        word_win.left  = prod_l[`PITCH_HANN_FRAC +: 16];   // Arithmetic >> 15
        word_win.right = prod_r[`PITCH_HANN_FRAC +: 16];
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            state     <= S_IDLE;
            mem_req   <= '0;
            wr_en     <= 1'b0;
            fill_done <= 1'b0;
            empty_run <= 1'b0;
            slot      <= 1'b0;
        end else begin
            wr_en     <= 1'b0;
            fill_done <= 1'b0;
            empty_run <= 1'b0;
            case (state)
                S_IDLE: begin
                    // Busy until the writer has released the last slot
                    if (start && slot_full == 2'b00) begin
                        src_q        <= src_addr;
                        hop          <= hop_next;
                        mem_req.read <= 1'b1;
                        mem_req.addr <= src_addr;   // Header word
                        slot         <= 1'b0;
                        first_frame  <= 1'b1;
                        frame_off    <= '0;
                        state        <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (finished) begin
                        length       <= hdr_len;
                        mem_req.read <= 1'b0;
                        if (hdr_len < mem_addr_t'(`PITCH_WINDOW_LEN)) begin
                            empty_run <= 1'b1;      // Not even one frame
                            state     <= S_EMPTY;
                        end else begin
                            state <= S_WAIT;
                        end
                    end
                end
                S_WAIT: begin
                    if (!slot_full[slot]) begin
                        mem_req.read <= 1'b1;
                        mem_req.addr <= src_q + frame_off + 1'b1;
                        idx          <= '0;
                        state        <= S_READ;
                    end
                end
                S_READ: begin
                    if (finished) begin
                        wr_en        <= 1'b1;
                        buf_wr.slot  <= slot;
                        buf_wr.index <= idx;
                        buf_wr.data  <= word_win;
                        mem_req.addr <= mem_req.addr + 1'b1;
                        idx          <= idx + 1'b1;
                        if (idx == win_idx_t'(`PITCH_WINDOW_LEN - 1)) begin
                            mem_req.read   <= 1'b0;
                            fill_done      <= 1'b1; // Lands with the last word
                            fill_tag.first <= first_frame;
                            fill_tag.last  <= last_frame;
                            first_frame    <= 1'b0;
                            slot           <= ~slot;
                            frame_off      <= frame_off + hop;
                            state          <= last_frame ? S_IDLE : S_WAIT;
                        end
                    end
                end
                S_EMPTY: begin
                    if (!empty_run) state <= S_IDLE;    // Writer's done goes out meanwhile
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/ola_writer.sv
// The last frame's tail is never written; sums wrap per channel without saturation
`include "pitch_config.svh"

module ola_writer
    import audio_pkg::*;
    import sdram_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  logic       start,
    input  mem_addr_t  dst_addr,
    input  logic [1:0] slot_full,
    input  frame_tag_t slot_tag,
    input  stereo_t    rd_data,
    input  logic       empty_run,
    input  logic       finished,
    output logic       rd_en,
    output logic       rd_slot,
    output win_idx_t   rd_index,
    output logic       slot_release,
    output mem_req_t   mem_req,
    output logic       done
);
    localparam int HOP_W = $clog2(`PITCH_SYN_HOP);

    typedef enum logic [2:0] {W_IDLE, W_WAIT, W_LOAD, W_SUM, W_MEM, W_COPY, W_REL} state_e;

    state_e           state;
    mem_addr_t        dst_q;
    mem_addr_t        out_off;          // 8 * k
    frame_tag_t       cur_tag;
    stereo_t          overlap [`PITCH_SYN_HOP];
    stereo_t          sum;
    logic             cp_vld;           // Tail word arriving from the buffer
    logic [HOP_W-1:0] cp_idx;

    always_comb begin
        sum = rd_data;
        if (!cur_tag.first) begin
            sum.left  = rd_data.left + overlap[rd_index[HOP_W-1:0]].left;
            sum.right = rd_data.right + overlap[rd_index[HOP_W-1:0]].right;
        end
    end

    // Second half of the window becomes the next overlap
    always_ff @(posedge i_clk) begin
        if (cp_vld) overlap[cp_idx] <= rd_data;
    end

    always_ff @(posedge i_clk) begin
        if (reset) begin
            state        <= W_IDLE;
            mem_req      <= '0;
            rd_en        <= 1'b0;
            rd_slot      <= 1'b0;
            slot_release <= 1'b0;
            done         <= 1'b0;
            cp_vld       <= 1'b0;
        end else begin
            rd_en        <= 1'b0;
            slot_release <= 1'b0;
            done         <= 1'b0;
            cp_vld       <= rd_en & rd_index[HOP_W];    // Indices 8..15 only
            cp_idx       <= rd_index[HOP_W-1:0];
            case (state)
                W_IDLE: begin
                    if (start && !done) begin   // Done cycle still closes the old run
                        dst_q   <= dst_addr;
                        out_off <= '0;
                        rd_slot <= 1'b0;
                        state   <= W_WAIT;
                    end
                end
                W_WAIT: begin
                    if (empty_run) begin
                        done  <= 1'b1;
                        state <= W_IDLE;
                    end else if (slot_release) begin
                        rd_slot <= ~rd_slot;    // Flag of the old slot still high here
                    end else if (slot_full[rd_slot]) begin
                        cur_tag  <= slot_tag;
                        rd_en    <= 1'b1;
                        rd_index <= '0;
                        state    <= W_LOAD;
                    end
                end
                W_LOAD: state <= W_SUM;         // Buffer read in flight
                W_SUM: begin
                    mem_req.write     <= 1'b1;
                    mem_req.addr      <= dst_q + out_off + mem_addr_t'(rd_index) + 1'b1;
                    mem_req.writedata <= sum;
                    state             <= W_MEM;
                end
                W_MEM: begin
                    if (finished) begin
                        mem_req.write <= 1'b0;
                        if (rd_index == win_idx_t'(`PITCH_SYN_HOP - 1) && cur_tag.last) begin
                            done         <= 1'b1;
                            slot_release <= 1'b1;
                            state        <= W_IDLE;
                        end else begin
                            rd_en    <= 1'b1;
                            rd_index <= rd_index + 1'b1;
                            // After word 7 go straight on to the tail
                            state <= (rd_index == win_idx_t'(`PITCH_SYN_HOP - 1)) ?
                                     W_COPY : W_LOAD;
                        end
                    end
                end
                W_COPY: begin
                    if (rd_index == win_idx_t'(`PITCH_WINDOW_LEN - 1)) begin
                        state <= W_REL;
                    end else begin
                        rd_en    <= 1'b1;       // Back to back reads
                        rd_index <= rd_index + 1'b1;
                    end
                end
                W_REL: begin
                    slot_release <= 1'b1;       // Word 15 captured this cycle
                    out_off      <= out_off + mem_addr_t'(`PITCH_SYN_HOP);
                    state        <= W_WAIT;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/pitch_config.svh
// Window must stay twice the hop and 16 words long, since the Hann table in audio_pkg is fixed
`ifndef PITCH_CONFIG_SVH
`define PITCH_CONFIG_SVH

// Frame geometry in stereo words
`define PITCH_WINDOW_LEN 16
`define PITCH_SYN_HOP    8    // Output words per frame

// speed is unsigned with 3 fraction bits, 8 means 1.0
`define PITCH_SPEED_FRAC 3

// SDRAM word address, header length field is also this wide
`define PITCH_ADDR_W     23

`define PITCH_HANN_FRAC  15   // Q15 window coefficients

`endif

// File: rtl/pitch_core.sv
// Time stretch only; start is ignored until done, and speed 0 runs as 1.0
module pitch_core
    import audio_pkg::*;
    import sdram_pkg::*;
(
    input  logic       i_clk,
    input  logic       reset,
    input  logic       start,
    input  mem_addr_t  src_addr,
    input  mem_addr_t  dst_addr,
    input  logic [3:0] speed,
    output logic       done,
    output mem_req_t   mem_req,
    input  mem_data_t  mem_readdata,
    input  logic       finished
);
    // Memory side, one request per unit
    mem_req_t   rd_req;
    mem_req_t   wr_req;
    logic       rd_finished;
    logic       wr_finished;

    // Reader to buffer
    logic       wr_en;
    buf_wr_t    buf_wr;
    logic       fill_done;
    frame_tag_t fill_tag;
    logic       empty_run;

    // Buffer to writer
    logic [1:0] slot_full;
    frame_tag_t slot_tag;
    logic       slot_release;
    logic       rd_en;
    logic       rd_slot;
    win_idx_t   rd_index;
    stereo_t    rd_data;

    frame_reader i_frame_reader (
        .mem_req  (rd_req),
        .finished (rd_finished),
        .*
    );

    frame_buffer i_frame_buffer (.*);

    ola_writer i_ola_writer (
        .mem_req  (wr_req),
        .finished (wr_finished),
        .*
    );

    sdram_arbiter i_sdram_arbiter (.*);

endmodule

// File: rtl/sdram_arbiter.sv
// Writer wins ties; a grant is only dropped on finished, so a requester must never withdraw
module sdram_arbiter
    import sdram_pkg::*;
(
    input  logic     i_clk,
    input  logic     reset,
    input  mem_req_t rd_req,
    input  mem_req_t wr_req,
    output logic     rd_finished,
    output logic     wr_finished,
    output mem_req_t mem_req,
    input  logic     finished
);
    typedef enum logic [1:0] {G_IDLE, G_RD, G_WR} grant_e;

    grant_e grant;
    logic   rd_want;
    logic   wr_want;

    assign rd_want = rd_req.read | rd_req.write;
    assign wr_want = wr_req.read | wr_req.write;

    always_ff @(posedge i_clk) begin
        if (reset) begin
            grant   <= G_IDLE;
            mem_req <= '0;
        end else begin
            case (grant)
                G_IDLE: begin
                    if (wr_want) begin          // Drain output first, keeps slots moving
                        grant   <= G_WR;
                        mem_req <= wr_req;
                    end else if (rd_want) begin
                        grant   <= G_RD;
                        mem_req <= rd_req;
                    end
                end
                default: begin
                    if (finished) begin
                        grant   <= G_IDLE;
                        mem_req <= '0;          // Bus idles one cycle between requests
                    end
                end
            endcase
        end
    end

    // Only the owner sees the handshake
    assign rd_finished = finished & (grant == G_RD);
    assign wr_finished = finished & (grant == G_WR);

endmodule

// File: rtl/sdram_pkg.sv
// One outstanding request at a time; read or write is a level held until finished
`include "pitch_config.svh"

package sdram_pkg;

    typedef logic [`PITCH_ADDR_W-1:0] mem_addr_t;   // Word address
    typedef logic [31:0]              mem_data_t;   // Stereo word or header

    typedef struct packed {
        logic      read;
        logic      write;
        mem_addr_t addr;
        mem_data_t writedata;                       // Ignored on reads
    } mem_req_t;

endpackage

// File: testbench/tb_pitch_core.sv
// One run at a time with sources 4K words apart; memory latency 0..3 cycles drawn from the LFSR
`include "pitch_config.svh"

module tb_pitch_core
    import audio_pkg::*;
    import sdram_pkg::*;
();
    localparam int NUM_RUNS = 13;
    localparam int RUN_GAP  = 20;       // Idle cycles after done, catches stray pulses

    logic       i_clk;
    logic       reset;
    logic       start;
    mem_addr_t  src_addr;
    mem_addr_t  dst_addr;
    logic [3:0] speed;
    logic       done;
    mem_req_t   mem_req;
    mem_data_t  mem_readdata;
    logic       finished;

    logic [31:0] mem [int];             // Sparse memory contents
    logic [31:0] exp_out [int];         // Expected output word per address
    bit          seen [int];            // Output addresses already written
    logic [15:0] lfsr_q;
    logic        pending;               // Request accepted, latency running
    logic [1:0]  lat_left;
    logic        run_active;
    int          cycles;
    int          cycle_limit;
    int          errors;
    int          tests_failed;
    int          wr_count;
    int          done_count;
    int          src_hits;
    int          cur_src;
    int          cur_len;
    int          cur_exp_writes;
    int          run_speed [NUM_RUNS];
    int          run_len   [NUM_RUNS];

    pitch_core i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int rand_speed();
        int s;
        s = int'(take_bits(4));
        return (s == 0) ? 1 : s;        // Keep to 1..15
    endfunction

    // Unwritten words read back as a pattern of the full address
    function automatic logic [31:0] mem_word(input int a);
        return mem.exists(a) ? mem[a] : 32'(a) * 32'h9E37_79B1;
    endfunction

    function automatic int hop_of(input int spd);
        int eff;
        eff = (spd == 0) ? (1 << `PITCH_SPEED_FRAC) : spd;     // 0 counts as 1.0
        return (`PITCH_SYN_HOP * eff) >> `PITCH_SPEED_FRAC;
    endfunction

    function automatic int frame_count(input int len, input int hop);
        if (len < `PITCH_WINDOW_LEN) return 0;
        return (len - `PITCH_WINDOW_LEN) / hop + 1;
    endfunction

    // Sample times Q15 coefficient, arithmetic shift back down
    function automatic logic [15:0] win_chan(input logic [15:0] x, input int i);
        int prod;
        prod = int'($signed(x)) * int'(hann_coef[i]);
        return 16'(prod >>> `PITCH_HANN_FRAC);
    endfunction

    task automatic build_expected(input int src, input int dst, input int hop, input int n);
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] win  [`PITCH_WINDOW_LEN];
        logic [31:0] tail [`PITCH_SYN_HOP];
        int          k;
        int          j;
        exp_out.delete();
        seen.delete();
        for (k = 0; k < n; k++) begin
            for (j = 0; j < `PITCH_WINDOW_LEN; j++) begin
                x      = mem_word(src + 1 + k * hop + j);
                win[j] = {win_chan(x[31:16], j), win_chan(x[15:0], j)};
            end
            for (j = 0; j < `PITCH_SYN_HOP; j++) begin
                y = win[j];                 // First frame has no tail
                if (k > 0) begin
                    y[31:16] = win[j][31:16] + tail[j][31:16];     // Wraps per channel
                    y[15:0]  = win[j][15:0] + tail[j][15:0];
                end
                exp_out[dst + 1 + `PITCH_SYN_HOP * k + j] = y;
                tail[j] = win[j + `PITCH_SYN_HOP];
            end
        end
    endtask

    task automatic check_write(input int a, input logic [31:0] d);
        wr_count++;
        if (!run_active) begin
            $display("Write at %h while no run was active", a);
            errors++;
        end
        if (a >= cur_src && a <= cur_src + cur_len) begin
            $display("Write at %h landed inside the source region", a);
            src_hits++;
            errors++;
        end
        if (!exp_out.exists(a)) begin
            $display("Write to unexpected address %h", a);
            errors++;
        end else begin
            if (seen.exists(a)) begin
                $display("Address %h written twice in one run", a);
                errors++;
            end
            seen[a] = 1'b1;
            if (d !== exp_out[a]) begin
                $display("FAILED mem_writedata at %h: expected %h, got %h", a, exp_out[a], d);
                errors++;
            end
        end
    endtask

    // Memory model and done monitor
    always @(posedge i_clk) begin : mem_model
        logic [1:0] lat;
        logic       serve;
        serve    = 1'b0;
        finished <= 1'b0;
        if (reset) begin
            pending <= 1'b0;
        end else if ((mem_req.read || mem_req.write) && !finished) begin
            if (!pending) begin
                lat = 2'(take_bits(2));
                if (lat == 2'd0) serve = 1'b1;
                else begin
                    pending  <= 1'b1;
                    lat_left <= lat - 2'd1;
                end
            end else if (lat_left == 2'd0) begin
                serve   = 1'b1;
                pending <= 1'b0;
            end else begin
                lat_left <= lat_left - 2'd1;
            end
        end
        if (serve) begin
            finished <= 1'b1;
            if (mem_req.read) mem_readdata <= mem_word(int'(mem_req.addr));
            if (mem_req.write) begin
                check_write(int'(mem_req.addr), mem_req.writedata);
                mem[int'(mem_req.addr)] = mem_req.writedata;
            end
        end
        if (!reset && done) begin
            done_count++;
            if (!run_active) begin
                $display("done pulsed while no run was active");
                errors++;
            end else if (wr_count != cur_exp_writes) begin
                $display("done pulsed after %0d of %0d writes", wr_count, cur_exp_writes);
                errors++;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, run did not finish", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Called right after a rising edge
    task automatic do_run(input int run, input int src, input int dst,
                          input logic new_data, input logic mid_start);
        int len;
        int spd;
        int hop;
        int n;
        int i;
        len = run_len[run];
        spd = run_speed[run];
        hop = hop_of(spd);
        n   = frame_count(len, hop);
        if (new_data) begin
            mem[src] = 32'(len) << 9;   // Length in bits 31..9
            for (i = 1; i <= len; i++) mem[src + i] = take_bits(32);
        end
        build_expected(src, dst, hop, n);
        cur_src        = src;
        cur_len        = len;
        cur_exp_writes = `PITCH_SYN_HOP * n;
        wr_count       = 0;
        done_count     = 0;
        run_active     = 1'b1;
        start    <= 1'b1;
        src_addr <= mem_addr_t'(src);
        dst_addr <= mem_addr_t'(dst);
        speed    <= 4'(spd);
        @(posedge i_clk);
        start <= 1'b0;
        if (mid_start) begin
            do @(posedge i_clk); while (wr_count < 4);
            start    <= 1'b1;           // Swapped regions, would hit the source if taken
            src_addr <= mem_addr_t'(dst);
            dst_addr <= mem_addr_t'(src);
            speed    <= 4'd1;
            @(posedge i_clk);
            start <= 1'b0;
        end
        while (done_count == 0) @(posedge i_clk);
        repeat (RUN_GAP) @(posedge i_clk);
        if (done_count != 1) begin
            $display("done pulsed %0d times in run %0d", done_count, run);
            errors++;
        end
        if (wr_count != cur_exp_writes) begin
            $display("Run %0d made %0d writes, %0d expected", run, wr_count, cur_exp_writes);
            errors++;
        end
        run_active = 1'b0;
    endtask

    task automatic end_test(input string name, input int new_errors);
        if (new_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, new_errors);
            tests_failed++;
        end
    endtask

    initial begin : stimulus
        int r;
        int mark;
        int n;
        int i;
        lfsr_q       = 16'd23;
        reset        = 1'b1;
        start        = 1'b0;
        src_addr     = '0;
        dst_addr     = '0;
        speed        = 4'd0;
        mem_readdata = '0;
        finished     = 1'b0;
        pending      = 1'b0;
        lat_left     = '0;
        run_active   = 1'b0;
        cycles       = 0;
        errors       = 0;
        tests_failed = 0;
        src_hits     = 0;
        wr_count     = 0;
        done_count   = 0;
        // Run table, drawn up front so the cycle limit is known
        run_speed[0] = 8;
        run_len[0]   = 64;
        for (r = 1; r <= 8; r++) begin
            run_speed[r] = rand_speed();
            run_len[r]   = 16 + int'(take_bits(7)) % 65;
        end
        run_speed[9]  = rand_speed();
        run_len[9]    = int'(take_bits(4));     // Short header, no frame
        run_speed[10] = 0;
        run_len[10]   = 48;
        run_speed[11] = 8;
        run_len[11]   = 48;
        run_speed[12] = rand_speed();
        run_len[12]   = 16 + int'(take_bits(6));
        cycle_limit = 8;
        for (r = 0; r < NUM_RUNS; r++) begin
            n = frame_count(run_len[r], hop_of(run_speed[r]));
            cycle_limit += 10 * (1 + n * 24) + 200;
        end
        repeat (8) @(posedge i_clk);
        reset <= 1'b0;
        @(posedge i_clk);

        mark = errors;
        do_run(0, 32'h1000, 32'h1000 + run_len[0], 1'b1, 1'b0);
        end_test("1 overlap-add values at speed 8", errors - mark);

        mark = errors;
        for (r = 1; r <= 8; r++) begin
            do_run(r, 32'h1000 * (r + 1), 32'h1000 * (r + 1) + run_len[r], 1'b1, 1'b0);
        end
        end_test("2 write count and addresses, random speed", errors - mark);

        mark = errors;
        do_run(9, 32'hA000, 32'hA000 + run_len[9], 1'b1, 1'b0);
        end_test("3 short length gives done only", errors - mark);

        mark = errors;
        do_run(10, 32'hB000, 32'hB000 + run_len[10], 1'b1, 1'b0);
        do_run(11, 32'hB000, 32'hB800, 1'b0, 1'b0);     // Same samples as speed 0
        n = frame_count(run_len[10], 8) * `PITCH_SYN_HOP;
        for (i = 1; i <= n; i++) begin
            if (mem_word(32'hB000 + run_len[10] + i) !== mem_word(32'hB800 + i)) begin
                $display("FAILED mem_writedata word %0d: speed 0 gave %h, speed 8 gave %h", i,
                         mem_word(32'hB000 + run_len[10] + i), mem_word(32'hB800 + i));
                errors++;
            end
        end
        end_test("4 speed 0 matches speed 8", errors - mark);

        mark = errors;
        do_run(12, 32'hC000, 32'hC000 + run_len[12], 1'b1, 1'b1);
        end_test("5 single done, start ignored mid-run", errors - mark);

        end_test("6 source regions untouched", src_hits);

        $display("6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
